// File: hw/histogram_macros.svh
`ifndef HISTOGRAM_MACROS_SVH
`define HISTOGRAM_MACROS_SVH

// time-bin index width, 16 bins per pixel
`define BIN_BITS 4

// pixel index width, 8 pixels
`define PIX_BITS 3

// histogram count width
// counts wrap modulo 2**CNT_BITS
`define CNT_BITS 8

// accepted events that close one frame
`define FRAME_EVENTS 200

`endif

// File: hw/histMemPkg.sv
`include "histogram_macros.svh"

package histMemPkg;

    // time-bin index inside one pixel histogram
    typedef logic [`BIN_BITS-1:0] binIdx;

    // one histogram word
    typedef logic [`CNT_BITS-1:0] histCount;

    // event address, also the histogram RAM address
    // pixel in the upper bits so a sweep walks one pixel's bins in order
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        binIdx                bin;
    } histAddr;

    // command bundle to the histogram RAM
    // addr is the read address, a write goes to the word read one cycle earlier
    typedef struct packed {
        histAddr  addr;
        logic     wrEn;
        logic     rdEn;
        histCount wrData;
    } memPort;

endpackage

// File: hw/histPeakPkg.sv
`include "histogram_macros.svh"

package histPeakPkg;

    // result RAM address, one word per pixel
    typedef logic [`PIX_BITS-1:0] pixelIdx;

    // peak of one pixel histogram
    // lowest bin wins on equal counts
    typedef struct packed {
        histMemPkg::binIdx    peakBin;
        histMemPkg::histCount peakCount;
    } peakRec;

endpackage

// File: hw/histRam.sv
`timescale 1ns/100ps

module histRam #(
    parameter type wordT = logic [7:0],
    parameter int depthBits = 4
) (
    input  logic                 clk,
    input  logic                 wrEn,
    input  logic [depthBits-1:0] wrAddr,
    input  wordT                 wrData,
    input  logic                 rdEn,
    input  logic [depthBits-1:0] rdAddr,
    output wordT                 rdData
);

    // storage array
    wordT mem [2**depthBits];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same address as a write in this cycle returns the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// File: hw/histBuilder.sv
`timescale 1ns/100ps
`include "histogram_macros.svh"

module histBuilder (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wrEn,
    input  histMemPkg::histAddr  addr,
    input  histMemPkg::histCount rdData,
    input  histMemPkg::memPort   scanCmd,
    input  logic                 scanActive,
    output histMemPkg::memPort   histCmd,
    output logic                 buildDone,
    output logic                 building
);

    import histMemPkg::*;

    // event counter width, holds 0 .. FRAME_EVENTS
    localparam int EvW = $clog2(`FRAME_EVENTS + 1);

    typedef enum logic [1:0] {
        Idle,
        Build,
        LastWr
    } stateT;

    stateT          state;
    stateT          stateNext;
    logic [EvW-1:0] evCnt;
    logic           accept;
    logic           frameEnd;
    logic           pendQ;
    logic           fwdQ;
    histAddr        evAddrQ;
    histCount       fwdData;
    histCount       baseCnt;
    histCount       incCnt;
    memPort         ownCmd;

    // frame is closing, from the last write until the sweep takes over
    assign building = (state == LastWr) || buildDone;

    // events while closing or sweeping are dropped
    assign accept = wrEn && !building && !scanActive;

    // this event is number FRAME_EVENTS
    assign frameEnd = accept && (evCnt == EvW'(`FRAME_EVENTS - 1));

    // same bin as the previous event, RAM data is stale
    assign baseCnt = fwdQ ? fwdData : rdData;
    assign incCnt  = baseCnt + histCount'(1);

    // read now, write the increment next cycle
    // the write address is the previous read address, kept in the top
    assign ownCmd.addr   = addr;
    assign ownCmd.rdEn   = accept;
    assign ownCmd.wrEn   = pendQ;
    assign ownCmd.wrData = incCnt;

    // RAM belongs to the peak finder while no frame is open
    assign histCmd = ((state != Idle) || accept) ? ownCmd : scanCmd;

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            Idle, Build: begin
                if (frameEnd) begin
                    stateNext = LastWr;
                end else if (accept) begin
                    stateNext = Build;
                end
            end
            // write of the final event
            LastWr: begin
                stateNext = Idle;
            end
            default: begin
                stateNext = Idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= Idle;
            evCnt     <= '0;
            pendQ     <= 1'b0;
            fwdQ      <= 1'b0;
            buildDone <= 1'b0;
        end else begin
            state     <= stateNext;
            // one cycle after the last write
            buildDone <= (state == LastWr);
            // increment due next cycle
            pendQ     <= accept;
            // back-to-back hit on the bin being written
            fwdQ      <= accept && pendQ && (addr == evAddrQ);
            if (frameEnd) begin
                evCnt <= '0;
            end else if (accept) begin
                evCnt <= evCnt + 1'b1;
            end
        end
    end

    // address of the pending write and the count going into the RAM
    always_ff @(posedge clk) begin
        if (accept) begin
            evAddrQ <= addr;
        end
        fwdData <= incCnt;
    end

endmodule

// File: hw/peakFinder.sv
`timescale 1ns/100ps

module peakFinder (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 buildDone,
    input  histMemPkg::histCount rdData,
    output histMemPkg::memPort   scanCmd,
    output logic                 scanActive,
    output logic                 resWrEn,
    output histPeakPkg::pixelIdx resAddr,
    output histPeakPkg::peakRec  resData,
    output logic                 peakDone
);

    import histMemPkg::*;
    import histPeakPkg::*;

    logic     reading;
    logic     rdPendQ;
    logic     finishQ;
    logic     clearMode;
    histAddr  scanAddr;
    histAddr  rdAddrQ;
    histCount maxCnt;
    binIdx    maxBin;
    histCount curCnt;
    binIdx    curBin;
    logic     lastBin;
    logic     lastWord;

    // read one word per cycle, zero the word read last cycle
    assign scanCmd.addr   = scanAddr;
    assign scanCmd.rdEn   = reading;
    assign scanCmd.wrEn   = rdPendQ;
    assign scanCmd.wrData = '0;

    // reads, data return and the final result write
    assign scanActive = reading | rdPendQ | finishQ;

    assign lastBin  = (rdAddrQ.bin == '1);
    assign lastWord = lastBin && (rdAddrQ.pixel == '1);

    // running maximum including the word now on rdData
    // bin 0 restarts the search for a new pixel
    // strictly greater keeps the lower bin on a tie
    always_comb begin
        if ((rdAddrQ.bin == '0) || (rdData > maxCnt)) begin
            curCnt = rdData;
            curBin = rdAddrQ.bin;
        end else begin
            curCnt = maxCnt;
            curBin = maxBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // clearing sweep starts straight out of reset
            reading   <= 1'b1;
            rdPendQ   <= 1'b0;
            finishQ   <= 1'b0;
            clearMode <= 1'b1;
            scanAddr  <= '0;
            resWrEn   <= 1'b0;
            peakDone  <= 1'b0;
        end else begin
            rdPendQ  <= reading;
            finishQ  <= rdPendQ && lastWord;
            // peak of a pixel is known on its last bin
            resWrEn  <= rdPendQ && lastBin && !clearMode;
            // one cycle after the final result write
            peakDone <= finishQ && !clearMode;
            if (finishQ) begin
                clearMode <= 1'b0;
            end
            if (buildDone && !scanActive) begin
                reading  <= 1'b1;
                scanAddr <= '0;
            end else if (reading) begin
                if (scanAddr == '1) begin
                    reading <= 1'b0;
                end
                scanAddr <= histAddr'(scanAddr + 1'b1);
            end
        end
    end

    // address tag of the returning word, maximum and result payload
    always_ff @(posedge clk) begin
        rdAddrQ <= scanAddr;
        if (rdPendQ) begin
            maxCnt <= curCnt;
            maxBin <= curBin;
        end
        if (rdPendQ && lastBin) begin
            resAddr <= rdAddrQ.pixel;
            resData <= '{peakBin: curBin, peakCount: curCnt};
        end
    end

endmodule

// File: hw/histogramTop.sv
`timescale 1ns/100ps

module histogramTop (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wrEn,
    input  histMemPkg::histAddr  addr,
    input  logic                 resultRd,
    input  histPeakPkg::pixelIdx resultPixel,
    output histPeakPkg::peakRec  result,
    output logic                 buildDone,
    output logic                 peakDone,
    output logic                 busy
);

    import histMemPkg::*;
    import histPeakPkg::*;

    memPort   histCmd;
    memPort   scanCmd;
    histCount histRd;
    histAddr  wbAddr;
    logic     building;
    logic     scanActive;
    logic     resWrEn;
    pixelIdx  resAddr;
    peakRec   resData;

    // no events taken while a frame closes or a sweep runs
    assign busy = building | scanActive;

    // writes go back to the word read one cycle earlier
    always_ff @(posedge clk) begin
        wbAddr <= histCmd.addr;
    end

    // histogram store
    histRam #(
        .wordT     (histCount),
        .depthBits ($bits(histAddr))
    ) histMem (
        .clk    (clk),
        .wrEn   (histCmd.wrEn),
        .wrAddr (wbAddr),
        .wrData (histCmd.wrData),
        .rdEn   (histCmd.rdEn),
        .rdAddr (histCmd.addr),
        .rdData (histRd)
    );

    // per-pixel peak store, read from outside
    histRam #(
        .wordT     (peakRec),
        .depthBits ($bits(pixelIdx))
    ) resMem (
        .clk    (clk),
        .wrEn   (resWrEn),
        .wrAddr (resAddr),
        .wrData (resData),
        .rdEn   (resultRd),
        .rdAddr (resultPixel),
        .rdData (result)
    );

    histBuilder builder0 (
        .clk        (clk),
        .res        (res),
        .wrEn       (wrEn),
        .addr       (addr),
        .rdData     (histRd),
        .scanCmd    (scanCmd),
        .scanActive (scanActive),
        .histCmd    (histCmd),
        .buildDone  (buildDone),
        .building   (building)
    );

    peakFinder finder0 (
        .clk        (clk),
        .res        (res),
        .buildDone  (buildDone),
        .rdData     (histRd),
        .scanCmd    (scanCmd),
        .scanActive (scanActive),
        .resWrEn    (resWrEn),
        .resAddr    (resAddr),
        .resData    (resData),
        .peakDone   (peakDone)
    );

endmodule

// File: bench/histogramTb_sva.sv
`timescale 1ns/100ps

module histogramTb_sva (
    input logic clk,
    input logic res,
    input logic donePulse,
    input logic ownCmd,
    input logic otherCmd,
    input logic resultWr,
    input logic clearing
);

    // read back by the testbench at the end of the run
    int failCount = 0;

    // done strobes are one cycle wide
    doneOneCycle: assert property (@(posedge clk) disable iff (!res) donePulse |=> !donePulse)
        else begin
            failCount++;
            $error("done strobe held high for more than one cycle");
        end

    // only one owner of the histogram RAM per cycle
    cmdExclusive: assert property (@(posedge clk) disable iff (!res) !(ownCmd && otherCmd))
        else begin
            failCount++;
            $error("histogram RAM driven by two commands in one cycle");
        end

    // locked-out write strobe
    // result write in the clearing sweep, or an increment during a sweep
    noClearResult: assert property (@(posedge clk) disable iff (!res) !(clearing && resultWr))
        else begin
            failCount++;
            $error("write strobe while it is locked out");
        end

    // and no done strobe in the locked-out phase either
    noClearDone: assert property (@(posedge clk) disable iff (!res) !(clearing && donePulse))
        else begin
            failCount++;
            $error("done strobe while it is locked out");
        end

endmodule

// pending increment write vs any sweep command
// frame end and increments only outside a sweep
bind histBuilder histogramTb_sva builderSva (
    .clk       (clk),
    .res       (res),
    .donePulse (buildDone),
    .ownCmd    (pendQ),
    .otherCmd  (scanCmd.rdEn | scanCmd.wrEn),
    .resultWr  (pendQ),
    .clearing  (scanActive)
);

// sweep must not start in the frame handover cycle
bind peakFinder histogramTb_sva finderSva (
    .clk       (clk),
    .res       (res),
    .donePulse (peakDone),
    .ownCmd    (scanCmd.rdEn | scanCmd.wrEn),
    .otherCmd  (buildDone),
    .resultWr  (resWrEn),
    .clearing  (clearMode)
);

// File: bench/histogramTb.sv
`timescale 1ns/100ps
`include "histogram_macros.svh"

module histogramTb;

    import histMemPkg::*;
    import histPeakPkg::*;

    localparam int NumPix = 1 << `PIX_BITS;
    localparam int NumBins = 1 << `BIN_BITS;
    localparam int NumFrames = 4;
    // one read per word plus pipeline
    localparam int SweepCycles = NumPix * NumBins + 8;
    // events with gaps, frame close, sweep, readback
    localparam int FrameCycles = 2 * `FRAME_EVENTS + SweepCycles + 2 * NumPix + 16;
    localparam int TimeoutCycles = 2 * (16 + SweepCycles + NumFrames * FrameCycles);
    // tie frame, events per pixel split into two tied bins and one lower bin
    localparam int TieEvents = `FRAME_EVENTS / NumPix;
    localparam int TieCnt = (TieEvents - 5) / 2;
    localparam int LowCnt = TieEvents - 2 * TieCnt;

    logic    clk;
    logic    res;
    logic    wrEn;
    histAddr addr;
    logic    resultRd;
    pixelIdx resultPixel;
    peakRec  result;
    logic    buildDone;
    logic    peakDone;
    logic    busy;

    integer seed;
    int     histModel [NumPix][NumBins];
    peakRec expPeak [NumPix];
    int     buildPulses = 0;
    int     peakPulses = 0;
    int     cycleCnt = 0;
    int     checkRequests = 0;
    int     checksDone = 0;
    int     framesDone = 0;

    histogramTop dut0 (
        .clk         (clk),
        .res         (res),
        .wrEn        (wrEn),
        .addr        (addr),
        .resultRd    (resultRd),
        .resultPixel (resultPixel),
        .result      (result),
        .buildDone   (buildDone),
        .peakDone    (peakDone),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // strobe counters, seen by the stimulus one negedge later
    always @(negedge clk) begin
        if (buildDone) begin
            buildPulses <= buildPulses + 1;
        end
        if (peakDone) begin
            peakPulses <= peakPulses + 1;
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    initial begin
        wait (cycleCnt >= TimeoutCycles);
        $display("Timeout: the run did not end within %0d clock cycles", TimeoutCycles);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    task automatic checkVal(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // expected peak of one pixel, lowest bin on equal counts
    function automatic peakRec refPeak(input int pix);
        peakRec rec;
        int     bestBin;
        bestBin = 0;
        for (int b = 1; b < NumBins; b++) begin
            if (histModel[pix][b] > histModel[pix][bestBin]) begin
                bestBin = b;
            end
        end
        rec.peakBin = binIdx'(bestBin);
        rec.peakCount = histCount'(histModel[pix][bestBin]);
        return rec;
    endfunction

    function automatic histAddr mkAddr(input int pix, input binIdx bin);
        histAddr a;
        a.pixel = pixelIdx'(pix);
        a.bin = bin;
        return a;
    endfunction

    function automatic histAddr randAddr();
        logic [31:0] r;
        r = $random(seed);
        return r[$bits(histAddr)-1:0];
    endfunction

    task automatic idleCycle();
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic randomGap();
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            idleCycle();
        end
    endtask

    // one accepted event, retried while busy
    task automatic sendEvent(input histAddr a);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            // no buildDone before the frame is full
            checkVal("buildDone pulses", buildPulses, framesDone);
            if (busy) begin
                wrEn = 1'b0;
            end else begin
                wrEn = 1'b1;
                addr = a;
                histModel[a.pixel][a.bin]++;
                taken = 1'b1;
            end
        end
    endtask

    // post-reset sweep, strobes here must be dropped
    task automatic waitIdle();
        logic [31:0] r;
        do begin
            @(negedge clk);
            r = $random(seed);
            wrEn = busy && r[0];
            addr = r[$bits(histAddr):1];
        end while (busy);
    endtask

    task automatic waitPeak(input bit strobeBusy);
        int          target;
        logic [31:0] r;
        target = peakPulses + 1;
        while (peakPulses < target) begin
            @(negedge clk);
            // busy holds from the frame close until peakDone
            if (!peakDone && (peakPulses < target)) begin
                checkVal("busy", busy, 1);
            end
            r = $random(seed);
            // not counted by the model
            wrEn = strobeBusy && busy && r[31];
            addr = r[$bits(histAddr)-1:0];
        end
    endtask

    task automatic finishFrame(input bit strobeBusy);
        waitPeak(strobeBusy);
        framesDone++;
        checkVal("buildDone pulses", buildPulses, framesDone);
        checkVal("peakDone pulses", peakPulses, framesDone);
        for (int p = 0; p < NumPix; p++) begin
            expPeak[p] = refPeak(p);
            for (int b = 0; b < NumBins; b++) begin
                histModel[p][b] = 0;
            end
        end
        // hand over to the result checker
        checkRequests++;
        wait (checksDone == checkRequests);
    endtask

    // runs on one bin and alternations of two bins, no gaps inside a run
    task automatic runFrame();
        histAddr     a;
        histAddr     b;
        int          left;
        int          len;
        bit          alt;
        logic [31:0] r;
        left = `FRAME_EVENTS;
        // long first run on a single bin
        len = 60;
        while (left > 0) begin
            r = $random(seed);
            a = randAddr();
            b = randAddr();
            alt = r[31] && (left != `FRAME_EVENTS);
            if (len > left) begin
                len = left;
            end
            for (int i = 0; i < len; i++) begin
                if (alt && i[0]) begin
                    sendEvent(b);
                end else begin
                    sendEvent(a);
                end
            end
            left -= len;
            idleCycle();
            len = 1 + int'(r[20:16]);
        end
    endtask

    // two bins per pixel with equal counts, a third one lower
    task automatic tieFrame();
        logic [31:0] r;
        binIdx       lo;
        binIdx       hi;
        binIdx       other;
        for (int p = 0; p < NumPix; p++) begin
            r = $random(seed);
            lo = r[`BIN_BITS-1:0];
            hi = r[2*`BIN_BITS-1:`BIN_BITS];
            if (hi == lo) begin
                hi = lo + 1'b1;
            end
            other = hi + 1'b1;
            if (other == lo) begin
                other = other + 1'b1;
            end
            for (int k = 0; k < TieCnt; k++) begin
                sendEvent(mkAddr(p, hi));
                sendEvent(mkAddr(p, lo));
            end
            repeat (LowCnt) sendEvent(mkAddr(p, other));
            randomGap();
        end
    endtask

    // result comparison, one read per pixel
    initial begin
        resultRd = 1'b0;
        resultPixel = '0;
        forever begin
            wait (checkRequests > checksDone);
            for (int p = 0; p < NumPix; p++) begin
                @(negedge clk);
                resultRd = 1'b1;
                resultPixel = pixelIdx'(p);
                @(negedge clk);
                resultRd = 1'b0;
                checkVal($sformatf("result[%0d].peakBin", p),
                    int'(result.peakBin), int'(expPeak[p].peakBin));
                checkVal($sformatf("result[%0d].peakCount", p),
                    int'(result.peakCount), int'(expPeak[p].peakCount));
            end
            checksDone++;
        end
    end

    initial begin
        int assertFails;
        seed = 32'ha9d591f8;
        res = 1'b0;
        wrEn = 1'b0;
        addr = '0;
        for (int p = 0; p < NumPix; p++) begin
            for (int b = 0; b < NumBins; b++) begin
                histModel[p][b] = 0;
            end
        end
        repeat (16) @(negedge clk);
        res = 1'b1;
        // clearing sweep owns the RAM right out of reset
        checkVal("busy", busy, 1);

        // clearing sweep ends without peakDone
        waitIdle();
        idleCycle();
        checkVal("peakDone pulses", peakPulses, 0);

        // random events with gaps
        repeat (`FRAME_EVENTS) begin
            sendEvent(randAddr());
            randomGap();
        end
        finishFrame(1'b0);

        // same-bin forwarding
        runFrame();
        finishFrame(1'b0);

        // ties go to the lower bin
        tieFrame();
        finishFrame(1'b0);

        // back-to-back random events, strobes while busy
        repeat (`FRAME_EVENTS) sendEvent(randAddr());
        finishFrame(1'b1);

        repeat (4) idleCycle();
        assertFails = dut0.builder0.builderSva.failCount + dut0.finder0.finderSva.failCount;
        if (assertFails == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", assertFails);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: flist.f
+incdir+hw
hw/histMemPkg.sv
hw/histPeakPkg.sv
hw/histRam.sv
hw/histBuilder.sv
hw/peakFinder.sv
hw/histogramTop.sv
bench/histogramTb_sva.sv
bench/histogramTb.sv

// File: run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module histogramTb -o histogramSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/histogramSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
